// File: compile.f
+incdir+dv
source/sobel_pkg.sv
source/ocl_reg_slave.sv
source/conv_reg_file.sv
source/sobel_filter.sv
source/vled_status.sv
source/cl_sobel_top.sv
dv/tb_cl_sobel.sv

// File: dv/tb_tasks.svh
// Register port access tasks and directed tests
// Included into the testbench top module
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// --------------------
// Check helpers
// --------------------
task automatic check_value(input string name, input logic [data_w-1:0] exp,
                           input logic [data_w-1:0] got);
  assert (got === exp) else begin
    $display("ERR %s expected 0x%h got 0x%h", name, exp, got);
    error_count++;
  end
endtask

task automatic check_flag(input logic cond, input string what);
  assert (cond === 1'b1) else begin
    $display("%s", what);
    error_count++;
  end
endtask

// --------------------
// Bus access
// --------------------
// Single write, bready held low for bp_cycles once bvalid is up
task automatic axil_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                          input int bp_cycles);
  @(negedge clk_main_a0);
  ocl_req.awvalid = 1'b1;
  ocl_req.awaddr  = addr;
  ocl_req.wvalid  = 1'b1;
  ocl_req.wdata   = data;
  ocl_req.bready  = 1'b0;
  // Address taken on the edge after awready is seen
  while (!ocl_rsp.awready) begin
    @(negedge clk_main_a0);
  end
  @(negedge clk_main_a0);
  ocl_req.awvalid = 1'b0;
  while (!ocl_rsp.wready) begin
    @(negedge clk_main_a0);
  end
  @(negedge clk_main_a0);
  ocl_req.wvalid = 1'b0;
  while (!ocl_rsp.bvalid) begin
    @(negedge clk_main_a0);
  end
  check_value("bresp", 32'(resp_okay), 32'(ocl_rsp.bresp));
  // Back-pressure on the response
  for (int i = 0; i < bp_cycles; i++) begin
    @(negedge clk_main_a0);
    check_flag(ocl_rsp.bvalid, "bvalid dropped while bready was low");
    check_flag(!ocl_rsp.awready, "awready rose before the write response was taken");
  end
  ocl_req.bready = 1'b1;
  @(negedge clk_main_a0);
  ocl_req.bready = 1'b0;
  check_flag(!ocl_rsp.bvalid, "bvalid still high after bready");
  check_flag(ocl_rsp.awready, "awready not back high after the write completed");
endtask

// Single read, rready held low for bp_cycles once rvalid is up
task automatic axil_read(input logic [addr_w-1:0] addr, input int bp_cycles,
                         output logic [data_w-1:0] data);
  @(negedge clk_main_a0);
  ocl_req.arvalid = 1'b1;
  ocl_req.araddr  = addr;
  ocl_req.rready  = 1'b0;
  while (!ocl_rsp.arready) begin
    @(negedge clk_main_a0);
  end
  @(negedge clk_main_a0);
  ocl_req.arvalid = 1'b0;
  while (!ocl_rsp.rvalid) begin
    @(negedge clk_main_a0);
  end
  data = ocl_rsp.rdata;
  check_value("rresp", 32'(resp_okay), 32'(ocl_rsp.rresp));
  for (int i = 0; i < bp_cycles; i++) begin
    @(negedge clk_main_a0);
    check_flag(ocl_rsp.rvalid, "rvalid dropped while rready was low");
    check_value("rdata", data, ocl_rsp.rdata);
    check_flag(!ocl_rsp.arready, "arready high while read data was pending");
  end
  ocl_req.rready = 1'b1;
  @(negedge clk_main_a0);
  ocl_req.rready = 1'b0;
  check_flag(!ocl_rsp.rvalid, "rvalid still high after rready");
  // Data bus clears once taken
  check_value("rdata", '0, ocl_rsp.rdata);
endtask

// --------------------
// Window helpers
// --------------------
function automatic logic [win_taps-1:0][pix_w-1:0] random_window();
  logic [win_taps-1:0][pix_w-1:0] w;
  for (int k = 0; k < win_taps; k++) begin
    w[k] = pix_w'($urandom);
  end
  return w;
endfunction

task automatic write_window(input logic [win_taps-1:0][pix_w-1:0] taps);
  for (int k = 0; k < win_taps; k++) begin
    axil_write(win_base_addr + addr_w'(4 * k), data_w'(taps[k]), 0);
  end
  cur_taps = taps;
endtask

task automatic write_mode(input logic [data_w-1:0] mode);
  axil_write(mode_addr, mode, 0);
  cur_horz = |mode;
endtask

// Filter output after the two-cycle settle time
task automatic check_result();
  logic [data_w-1:0] data;
  repeat (2) @(negedge clk_main_a0);
  axil_read(result_addr, 0, data);
  check_value("result", data_w'(expected_sobel(cur_taps, cur_horz)), data);
endtask

// --------------------
// Directed tests
// --------------------
task automatic test_reset_values();
  logic [data_w-1:0] data;
  check_flag(ocl_rsp.awready, "awready low after reset");
  check_flag(ocl_rsp.arready, "arready low after reset");
  check_flag(!ocl_rsp.bvalid, "bvalid high after reset");
  check_flag(!ocl_rsp.rvalid, "rvalid high after reset");
  check_flag(!ocl_rsp.wready, "wready high with no write active");
  check_value("status_vled", '0, data_w'(status_vled));
  axil_read(result_addr, 0, data);
  check_value("result", '0, data);
  axil_read(vled_addr, 0, data);
  check_value("vled", '0, data);
endtask

task automatic test_vertical_filter();
  write_mode('0);
  write_window(random_window());
  check_result();
endtask

task automatic test_horizontal_filter();
  logic [win_taps-1:0][pix_w-1:0] w;
  write_mode($urandom | 32'h1);
  write_window(random_window());
  check_result();
  // Extreme rows force the sum to wrap
  w = random_window();
  w[0] = 12'h7FF;
  w[1] = 12'h7FF;
  w[2] = 12'h7FF;
  w[6] = 12'h800;
  w[7] = 12'h800;
  w[8] = 12'h800;
  write_window(w);
  check_result();
  // Same with extreme columns in vertical mode
  write_mode('0);
  w = random_window();
  w[0] = 12'h7FF;
  w[3] = 12'h7FF;
  w[6] = 12'h7FF;
  w[2] = 12'h800;
  w[5] = 12'h800;
  w[8] = 12'h800;
  write_window(w);
  check_result();
endtask

task automatic test_led_masking();
  logic [data_w-1:0] scratch;
  logic [vled_w-1:0] vdip;
  logic [data_w-1:0] data;
  scratch = $urandom;
  vdip    = vled_w'($urandom);
  // Scratch shares the result address
  axil_write(result_addr, scratch, 0);
  @(negedge clk_main_a0);
  status_vdip = vdip;
  // DIP sync plus output flop
  repeat (4) @(negedge clk_main_a0);
  check_value("status_vled", data_w'(scratch[vled_w-1:0] & vdip), data_w'(status_vled));
  axil_read(vled_addr, 0, data);
  check_value("vled", data_w'(scratch[vled_w-1:0]), data);
  // Result read unaffected by the scratch write
  axil_read(result_addr, 0, data);
  check_value("result", data_w'(expected_sobel(cur_taps, cur_horz)), data);
endtask

task automatic test_unimpl_backpressure();
  logic [data_w-1:0] data;
  logic [data_w-1:0] scratch;
  axil_read(32'h0000_0700, 3 + ($urandom % 6), data);
  check_value("rdata unmapped", unimpl_value, data);
  // Write-only registers read back as unmapped
  axil_read(mode_addr, 3 + ($urandom % 6), data);
  check_value("rdata mode", unimpl_value, data);
  axil_read(win_base_addr, 0, data);
  check_value("rdata window", unimpl_value, data);
  scratch = $urandom;
  axil_write(result_addr, scratch, 3 + ($urandom % 6));
  repeat (2) @(negedge clk_main_a0);
  axil_read(vled_addr, 0, data);
  check_value("vled", data_w'(scratch[vled_w-1:0]), data);
endtask

`endif

// File: dv/tb_cl_sobel.sv
// Testbench for the Sobel register block
// Directed register tests checked against a Sobel reference model
`timescale 1ns/1ps
`default_nettype none

module tb_cl_sobel;

  import sobel_pkg::*;

  localparam int num_tests       = 5;
  localparam int cycles_per_test = 200;
  localparam int reset_cycles    = 10;

  logic              clk_main_a0;
  logic              rst_main_n_sync;
  axil_req_t         ocl_req;
  axil_rsp_t         ocl_rsp;
  logic [vled_w-1:0] status_vdip;
  logic [vled_w-1:0] status_vled;

  int unsigned error_count;

  // Window and mode last written by the host
  logic [win_taps-1:0][pix_w-1:0] cur_taps;
  logic                           cur_horz;

  // --------------------
  // Clock and DUT
  // --------------------
  initial begin
    clk_main_a0 = 1'b0;
  end

  // 40 ns period
  always #20 clk_main_a0 = ~clk_main_a0;

  cl_sobel_top cl_sobel_top_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_req         (ocl_req),
    .ocl_rsp         (ocl_rsp),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled)
  );

  // Sobel sum from the kernel definitions, wrapped to pixel width
  function automatic logic [pix_w-1:0] expected_sobel(
    input logic [win_taps-1:0][pix_w-1:0] taps,
    input logic                           horz
  );
    int p [win_taps];
    int s;
    for (int k = 0; k < win_taps; k++) begin
      p[k] = int'($signed(taps[k]));
    end
    if (horz) begin
      // Top row minus bottom row
      s = p[0] + 2 * p[1] + p[2] - p[6] - 2 * p[7] - p[8];
    end else begin
      // Left column minus right column
      s = p[0] + 2 * p[3] + p[6] - p[2] - 2 * p[5] - p[8];
    end
    return s[pix_w-1:0];
  endfunction

  `include "tb_tasks.svh"

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    void'($urandom(72716));
    error_count     = 0;
    cur_taps        = '0;
    cur_horz        = 1'b0;
    ocl_req         = '0;
    status_vdip     = '0;
    rst_main_n_sync = 1'b0;

    // Reset released on a falling edge
    repeat (reset_cycles) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    @(negedge clk_main_a0);

    test_reset_values();
    test_vertical_filter();
    test_horizontal_filter();
    test_led_masking();
    test_unimpl_backpressure();

    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog budget scales with the number of tests
  initial begin
    repeat (reset_cycles + cycles_per_test * num_tests) @(posedge clk_main_a0);
    $display("Timeout: tests did not complete within %0d cycles",
             reset_cycles + cycles_per_test * num_tests);
    $display("Errors: %0d", error_count);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/cl_sobel_top.sv
// Sobel accelerator top level
// Register slave, register file, filter and LED block
`timescale 1ns/1ps
`default_nettype none

module cl_sobel_top (
  input  logic                         clk_main_a0,
  input  logic                         rst_main_n_sync,
  input  sobel_pkg::axil_req_t         ocl_req,
  output sobel_pkg::axil_rsp_t         ocl_rsp,
  input  logic [sobel_pkg::vled_w-1:0] status_vdip,
  output logic [sobel_pkg::vled_w-1:0] status_vled
);

  import sobel_pkg::*;

  // Slave to register file
  reg_wr_t           reg_wr;
  logic [addr_w-1:0] rd_addr;
  logic [data_w-1:0] rd_data;

  // Register file to filter and back
  conv_window_t      window;
  logic              horz;
  pixel_t            result;

  // Register file to LED block and back
  logic [vled_w-1:0] scratch_lo;
  logic [vled_w-1:0] vled_q;

  // --------------------
  // Host access
  // --------------------
  ocl_reg_slave ocl_reg_slave_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_req         (ocl_req),
    .ocl_rsp         (ocl_rsp),
    .reg_wr          (reg_wr),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  conv_reg_file conv_reg_file_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .window          (window),
    .horz            (horz),
    .scratch_lo      (scratch_lo),
    .result          (result),
    .vled_q          (vled_q)
  );

  // --------------------
  // Datapath
  // --------------------
  sobel_filter sobel_filter_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .window          (window),
    .horz            (horz),
    .result          (result)
  );

  vled_status vled_status_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .scratch_lo      (scratch_lo),
    .status_vdip     (status_vdip),
    .vled_q          (vled_q),
    .status_vled     (status_vled)
  );

endmodule

`default_nettype wire

// File: source/vled_status.sv
// Virtual LED block
// Shadows the scratch word, masks it with synchronized DIP switches
`timescale 1ns/1ps
`default_nettype none

module vled_status (
  input  logic                         clk_main_a0,
  input  logic                         rst_main_n_sync,
  input  logic [sobel_pkg::vled_w-1:0] scratch_lo,
  input  logic [sobel_pkg::vled_w-1:0] status_vdip,
  output logic [sobel_pkg::vled_w-1:0] vled_q,
  output logic [sobel_pkg::vled_w-1:0] status_vled
);

  import sobel_pkg::*;

  // DIP switch synchronizer stages
  logic [vled_w-1:0] vdip_q1;
  logic [vled_w-1:0] vdip_q2;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1     <= '0;
      vdip_q2     <= '0;
      vled_q      <= '0;
      status_vled <= '0;
    end else begin
      // Two flops on the asynchronous switch inputs
      vdip_q1     <= status_vdip;
      vdip_q2     <= vdip_q1;
      // LED shadow trails scratch by a cycle
      vled_q      <= scratch_lo;
      // Registered masked output, DIP to LED in 3 cycles
      status_vled <= vled_q & vdip_q2;
    end
  end

endmodule

`default_nettype wire

// File: source/sobel_filter.sv
// 3x3 Sobel filter, one registered stage
// Mode picks horizontal or vertical kernel, sum wraps to pixel width
`timescale 1ns/1ps
`default_nettype none

module sobel_filter (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  input  sobel_pkg::conv_window_t window,
  input  logic                    horz,
  output sobel_pkg::pixel_t       result
);

  import sobel_pkg::*;

  // Both kernels reduce to a + 2b + c - d - 2e - f,
  // only the tap picked for each term differs
  //
  //   vertical     horizontal
  //   +1  0 -1     +1 +2 +1
  //   +2  0 -2      0  0  0
  //   +1  0 -1     -1 -2 -1

  // Positive column or row
  pixel_t op_a;
  pixel_t op_b;
  pixel_t op_c;
  // Negative column or row
  pixel_t op_d;
  pixel_t op_e;
  pixel_t op_f;

  pixel_t sum_pos;
  pixel_t sum_neg;
  pixel_t sum;

  // --------------------
  // Coefficient select
  // --------------------
  always_comb begin
    // Corner taps p0 and p8 appear in both kernels
    op_a = window[0];
    op_f = window[8];
    if (horz) begin
      // Top row minus bottom row
      op_b = window[1];
      op_c = window[2];
      op_d = window[6];
      op_e = window[7];
    end else begin
      // Left column minus right column
      op_b = window[3];
      op_c = window[6];
      op_d = window[2];
      op_e = window[5];
    end
  end

  // Pixel-width arithmetic, overflow wraps modulo 2^12
  always_comb begin
    sum_pos = op_a + (op_b <<< 1) + op_c;
    sum_neg = op_d + (op_e <<< 1) + op_f;
    sum     = sum_pos - sum_neg;
  end

  // --------------------
  // Output stage
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      result <= '0;
    end else begin
      result <= sum;
    end
  end

endmodule

`default_nettype wire

// File: source/conv_reg_file.sv
// Sobel register file
// Holds window taps, mode and scratch word, decodes reads
`timescale 1ns/1ps
`default_nettype none

module conv_reg_file (
  input  logic                             clk_main_a0,
  input  logic                             rst_main_n_sync,
  input  sobel_pkg::reg_wr_t               reg_wr,
  input  logic [sobel_pkg::addr_w-1:0]     rd_addr,
  output logic [sobel_pkg::data_w-1:0]     rd_data,
  output sobel_pkg::conv_window_t          window,
  output logic                             horz,
  output logic [sobel_pkg::vled_w-1:0]     scratch_lo,
  input  sobel_pkg::pixel_t                result,
  input  logic [sobel_pkg::vled_w-1:0]     vled_q
);

  import sobel_pkg::*;

  conv_window_t        win_q;
  logic [data_w-1:0]   mode_q;
  logic [data_w-1:0]   scratch_q;

  // Per-register write hits
  logic [win_taps-1:0] win_hit;
  logic                mode_hit;
  logic                scratch_hit;

  // --------------------
  // Write decode
  // --------------------
  always_comb begin
    for (int k = 0; k < win_taps; k++) begin
      // Taps are word spaced from the base
      win_hit[k] = reg_wr.en && (reg_wr.addr == win_base_addr + addr_w'(4 * k));
    end
    mode_hit    = reg_wr.en && (reg_wr.addr == mode_addr);
    // Scratch shares the result address, write side only
    scratch_hit = reg_wr.en && (reg_wr.addr == result_addr);
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      win_q     <= '0;
      mode_q    <= '0;
      scratch_q <= '0;
    end else begin
      for (int k = 0; k < win_taps; k++) begin
        // Only the pixel bits are kept
        if (win_hit[k]) begin
          win_q[k] <= pixel_t'(reg_wr.data[pix_w-1:0]);
        end
      end
      if (mode_hit) begin
        mode_q <= reg_wr.data;
      end
      if (scratch_hit) begin
        scratch_q <= reg_wr.data;
      end
    end
  end

  assign window     = win_q;
  // Any nonzero mode word means horizontal
  assign horz       = |mode_q;
  assign scratch_lo = scratch_q[vled_w-1:0];

  // --------------------
  // Read mux
  // --------------------
  // Window and mode are write only, they fall to the default
  always_comb begin
    case (rd_addr)
      result_addr: rd_data = {{(data_w - pix_w){1'b0}}, result};
      vled_addr:   rd_data = {{(data_w - vled_w){1'b0}}, vled_q};
      default:     rd_data = unimpl_value;
    endcase
  end

  // Register map must not overlap
  a_one_write: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $onehot0({win_hit, mode_hit, scratch_hit}));

endmodule

`default_nettype wire

// File: source/ocl_reg_slave.sv
// Register port slave, single-beat accesses only
// Turns host valid/ready traffic into write strobes and read lookups
`timescale 1ns/1ps
`default_nettype none

module ocl_reg_slave (
  input  logic                             clk_main_a0,
  input  logic                             rst_main_n_sync,
  input  sobel_pkg::axil_req_t             ocl_req,
  output sobel_pkg::axil_rsp_t             ocl_rsp,
  output sobel_pkg::reg_wr_t               reg_wr,
  output logic [sobel_pkg::addr_w-1:0]     rd_addr,
  input  logic [sobel_pkg::data_w-1:0]     rd_data
);

  import sobel_pkg::*;

  // Write channel state
  logic              wr_active;
  logic [addr_w-1:0] wr_addr;
  logic              aw_hs;
  logic              wready;
  logic              bvalid;

  // Read channel state
  logic              arready;
  logic              ar_hs;
  logic              arvalid_q;
  logic [addr_w-1:0] araddr_q;
  logic              rvalid;
  logic [data_w-1:0] rdata;

  // --------------------
  // Write path
  // --------------------
  // Address taken only when idle
  assign aw_hs  = ocl_req.awvalid && !wr_active;
  // One data beat per write, blocked once the response is up
  assign wready = wr_active && !bvalid && ocl_req.wvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end else if (bvalid && ocl_req.bready) begin
      // Response taken, slave free again
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      if (aw_hs) begin
        wr_active <= 1'b1;
      end
      // Response follows the data beat by one cycle
      if (wready) begin
        bvalid <= 1'b1;
      end
    end
  end

  // Address holding regs
  always_ff @(posedge clk_main_a0) begin
    if (aw_hs) begin
      wr_addr <= ocl_req.awaddr;
    end
    if (ar_hs) begin
      araddr_q <= ocl_req.araddr;
    end
  end

  // Strobe goes out in the wready cycle itself
  assign reg_wr.en   = wready;
  assign reg_wr.addr = wr_addr;
  assign reg_wr.data = ocl_req.wdata;

  // --------------------
  // Read path
  // --------------------
  // Nothing pending and no data waiting
  assign arready = !arvalid_q && !rvalid;
  assign ar_hs   = ocl_req.arvalid && arready;
  assign rd_addr = araddr_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      arvalid_q <= 1'b0;
      rvalid    <= 1'b0;
      rdata     <= '0;
    end else begin
      arvalid_q <= ar_hs;
      if (rvalid && ocl_req.rready) begin
        rvalid <= 1'b0;
        rdata  <= '0;
      end else if (arvalid_q) begin
        // Sample the register file mux for the latched address
        rvalid <= 1'b1;
        rdata  <= rd_data;
      end
    end
  end

  // Response bundle
  always_comb begin
    ocl_rsp.awready = !wr_active;
    ocl_rsp.wready  = wready;
    ocl_rsp.bvalid  = bvalid;
    ocl_rsp.bresp   = resp_okay;
    ocl_rsp.arready = arready;
    ocl_rsp.rvalid  = rvalid;
    ocl_rsp.rdata   = rdata;
    ocl_rsp.rresp   = resp_okay;
  end

  // --------------------
  // Protocol checks
  // --------------------
  // Write response stays up under back-pressure
  a_bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !ocl_req.bready |=> bvalid);

  // Read data stays up and stable until taken
  a_rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !ocl_req.rready |=> rvalid && $stable(rdata));

  // Data beat only inside an active write, then the response and no second beat
  a_wready_active: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wready |-> wr_active ##1 (bvalid && !wready));

endmodule

`default_nettype wire

// File: source/sobel_pkg.sv
// Sobel register block shared definitions
// Widths, register map, response codes and bus structs
`default_nettype none

package sobel_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int data_w   = 32;
  localparam int addr_w   = 32;
  localparam int pix_w    = 12;
  localparam int vled_w   = 16;
  localparam int win_taps = 9;

  // --------------------
  // Register map
  // --------------------
  // Read gives filter result, write loads scratch
  localparam logic [addr_w-1:0] result_addr   = 32'h0000_0500;
  // LED shadow, read only
  localparam logic [addr_w-1:0] vled_addr     = 32'h0000_0504;
  // Tap k at base + 4*k
  localparam logic [addr_w-1:0] win_base_addr = 32'h0000_0600;
  // Nonzero selects horizontal kernel
  localparam logic [addr_w-1:0] mode_addr     = 32'h0000_0630;

  // Returned for any unmapped read
  localparam logic [data_w-1:0] unimpl_value  = 32'hDEAD_BEEF;
  localparam logic [1:0]        resp_okay     = 2'b00;

  // --------------------
  // Types
  // --------------------
  typedef logic signed [pix_w-1:0] pixel_t;

  // Tap 0 top left, tap 8 bottom right, row order
  typedef pixel_t [win_taps-1:0] conv_window_t;

  // Host side of the register port
  typedef struct packed {
    logic              awvalid;
    logic [addr_w-1:0] awaddr;
    logic              wvalid;
    logic [data_w-1:0] wdata;
    logic              bready;
    logic              arvalid;
    logic [addr_w-1:0] araddr;
    logic              rready;
  } axil_req_t;

  // Slave side of the register port
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [data_w-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

  // Single-cycle write strobe into the register file
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } reg_wr_t;

endpackage

`default_nettype wire
